//--- src/cordic_params.svh
`ifndef CORDIC_PARAMS_SVH
`define CORDIC_PARAMS_SVH

// sample and direction vector widths
`define CORDIC_DATA_W    18
`define CORDIC_ANGLE_W   14

// micro-rotations per pipeline segment, shifts 0..3, 4..8 and 9..13
`define CORDIC_SEG0_LEN  4
`define CORDIC_SEG1_LEN  5
`define CORDIC_SEG2_LEN  5

`define CORDIC_LATENCY   4    // three segments plus gain stage

// 1/1.6468 in Q1.14
`define CORDIC_GAIN_W    15
`define CORDIC_GAIN_FRAC 14
`define CORDIC_GAIN_K    15'sd9949

`endif

//--- src/cordic_pkg.sv
`default_nettype none

`include "cordic_params.svh"

package cordic_pkg;

    typedef logic signed [`CORDIC_DATA_W-1:0] data_t;
    typedef logic signed [`CORDIC_DATA_W:0]   ext_t;    // one guard bit for growth
    typedef logic [`CORDIC_ANGLE_W-1:0]       dir_t;    // 1 = signs differed
    typedef logic [`CORDIC_LATENCY-2:0]       seg_valid_t;

    typedef enum logic {
        VECTOR = 1'b0,
        ROTATE = 1'b1
    } mode_e;

    // spread one flag per segment over the direction bits it owns
    function automatic dir_t seg_mask(seg_valid_t v);
        dir_t m;
        for (int i = 0; i < `CORDIC_ANGLE_W; i++) begin
            if (i < `CORDIC_SEG0_LEN) begin
                m[i] = v[0];
            end else if (i < `CORDIC_SEG0_LEN + `CORDIC_SEG1_LEN) begin
                m[i] = v[1];
            end else begin
                m[i] = v[2];
            end
        end
        return m;
    endfunction

endpackage

`default_nettype wire

//--- src/pe_pkg.sv
`default_nettype none

package pe_pkg;

    localparam int LANES = 2;

    typedef enum logic [1:0] {
        BOTH_VECTOR        = 2'b00,
        BOTH_ROTATE        = 2'b01,
        SWAP_VECTOR_ROTATE = 2'b10,   // lane 1 follows lane 0's fresh bits
        SWAP_ROTATE        = 2'b11
    } scheme_e;

    typedef logic [LANES-1:0] lane_valid_t;

endpackage

`default_nettype wire

//--- src/cordic_segment.sv
`default_nettype none

module cordic_segment #(
    parameter int FIRST_SHIFT = 0,
    parameter int LEN         = 4
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire cordic_pkg::mode_e   mode_i,
    input  wire cordic_pkg::ext_t    x_i,
    input  wire cordic_pkg::ext_t    y_i,
    input  wire [LEN-1:0]            dir_i,
    output cordic_pkg::ext_t         x_o,
    output cordic_pkg::ext_t         y_o,
    output logic [LEN-1:0]           dir_o
);

    localparam int MSB = $bits(cordic_pkg::ext_t) - 1;

    cordic_pkg::ext_t xs [0:LEN];
    cordic_pkg::ext_t ys [0:LEN];
    logic [LEN-1:0]   dir_sel;

    // unrolled shift-and-add chain
    always_comb begin
        xs[0] = x_i;
        ys[0] = y_i;
        for (int k = 0; k < LEN; k++) begin
            if (mode_i == cordic_pkg::VECTOR) begin
                dir_sel[k] = xs[k][MSB] ^ ys[k][MSB];   // drive y toward zero
            end else begin
                dir_sel[k] = dir_i[k];
            end
            if (dir_sel[k]) begin
                xs[k+1] = xs[k] - (ys[k] >>> (FIRST_SHIFT + k));
                ys[k+1] = ys[k] + (xs[k] >>> (FIRST_SHIFT + k));
            end else begin
                xs[k+1] = xs[k] + (ys[k] >>> (FIRST_SHIFT + k));
                ys[k+1] = ys[k] - (xs[k] >>> (FIRST_SHIFT + k));
            end
        end
    end

    assign dir_o = (mode_i == cordic_pkg::VECTOR) ? dir_sel : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_o <= '0;
            y_o <= '0;
        end else begin
            x_o <= xs[LEN];
            y_o <= ys[LEN];
        end
    end

endmodule

`default_nettype wire

//--- src/cordic_vr.sv
`default_nettype none

`include "cordic_params.svh"

module cordic_vr (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start_i,
    input  wire cordic_pkg::mode_e   mode_i,
    input  wire cordic_pkg::data_t   x_i,
    input  wire cordic_pkg::data_t   y_i,
    input  wire cordic_pkg::dir_t    dir_i,
    output cordic_pkg::data_t        x_o,
    output cordic_pkg::data_t        y_o,
    output cordic_pkg::dir_t         dir_o,
    output cordic_pkg::seg_valid_t   dir_valid_o
);

    localparam int SEG1_LO = `CORDIC_SEG0_LEN;
    localparam int SEG2_LO = `CORDIC_SEG0_LEN + `CORDIC_SEG1_LEN;
    localparam int PROD_W  = $bits(cordic_pkg::ext_t) + `CORDIC_GAIN_W;
    localparam logic signed [`CORDIC_GAIN_W-1:0] GAIN_K = `CORDIC_GAIN_K;

    cordic_pkg::mode_e        mode_eff;
    cordic_pkg::mode_e        mode_q [0:`CORDIC_LATENCY-3];
    cordic_pkg::ext_t         x_ext;
    cordic_pkg::ext_t         y_ext;
    cordic_pkg::ext_t         x_s0;
    cordic_pkg::ext_t         y_s0;
    cordic_pkg::ext_t         x_s1;
    cordic_pkg::ext_t         y_s1;
    cordic_pkg::ext_t         x_s2;
    cordic_pkg::ext_t         y_s2;
    logic signed [PROD_W-1:0] x_prod;
    logic signed [PROD_W-1:0] y_prod;

    always_comb begin
        if (start_i) begin
            mode_eff = mode_i;
        end else begin
            mode_eff = cordic_pkg::ROTATE;  // idle lane never reports directions
        end
    end

    assign x_ext = {x_i[`CORDIC_DATA_W-1], x_i};
    assign y_ext = {y_i[`CORDIC_DATA_W-1], y_i};

    cordic_segment #(.FIRST_SHIFT(0), .LEN(`CORDIC_SEG0_LEN)) i_seg0 (
        .clk(clk), .rst_n(rst_n), .mode_i(mode_eff),
        .x_i(x_ext), .y_i(y_ext), .dir_i(dir_i[SEG1_LO-1:0]),
        .x_o(x_s0), .y_o(y_s0), .dir_o(dir_o[SEG1_LO-1:0])
    );

    cordic_segment #(.FIRST_SHIFT(SEG1_LO), .LEN(`CORDIC_SEG1_LEN)) i_seg1 (
        .clk(clk), .rst_n(rst_n), .mode_i(mode_q[0]),
        .x_i(x_s0), .y_i(y_s0), .dir_i(dir_i[SEG2_LO-1:SEG1_LO]),
        .x_o(x_s1), .y_o(y_s1), .dir_o(dir_o[SEG2_LO-1:SEG1_LO])
    );

    cordic_segment #(.FIRST_SHIFT(SEG2_LO), .LEN(`CORDIC_SEG2_LEN)) i_seg2 (
        .clk(clk), .rst_n(rst_n), .mode_i(mode_q[1]),
        .x_i(x_s1), .y_i(y_s1), .dir_i(dir_i[`CORDIC_ANGLE_W-1:SEG2_LO]),
        .x_o(x_s2), .y_o(y_s2), .dir_o(dir_o[`CORDIC_ANGLE_W-1:SEG2_LO])
    );

    assign dir_valid_o = {mode_q[1] == cordic_pkg::VECTOR,
                          mode_q[0] == cordic_pkg::VECTOR,
                          mode_eff == cordic_pkg::VECTOR};

    assign x_prod = x_s2 * GAIN_K;
    assign y_prod = y_s2 * GAIN_K;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORDIC_LATENCY - 2; i++) begin
                mode_q[i] <= cordic_pkg::ROTATE;
            end
            x_o <= '0;
            y_o <= '0;
        end else begin
            mode_q[0] <= mode_eff;
            for (int i = 1; i < `CORDIC_LATENCY - 2; i++) begin
                mode_q[i] <= mode_q[i-1];
            end
            // drop the Q1.14 fraction of the gain
            x_o <= x_prod[`CORDIC_GAIN_FRAC+`CORDIC_DATA_W-1:`CORDIC_GAIN_FRAC];
            y_o <= y_prod[`CORDIC_GAIN_FRAC+`CORDIC_DATA_W-1:`CORDIC_GAIN_FRAC];
        end
    end

    // a vectoring launch leaves y close to the x axis
    vector_conv_a: assert property (@(posedge clk) disable iff (!rst_n)
        $past(mode_q[1] == cordic_pkg::VECTOR) |->
            ((y_s2 < 0) ? -y_s2 : y_s2) <= (((x_s2 < 0) ? -x_s2 : x_s2) >>> 11) + 32);

endmodule

`default_nettype wire

//--- src/givens_pe.sv
`default_nettype none

`include "cordic_params.svh"

module givens_pe (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire pe_pkg::lane_valid_t   lane_valid_i,
    input  wire pe_pkg::scheme_e       scheme_i,
    input  wire cordic_pkg::data_t     x0_i,
    input  wire cordic_pkg::data_t     y0_i,
    input  wire cordic_pkg::data_t     x1_i,
    input  wire cordic_pkg::data_t     y1_i,
    input  wire cordic_pkg::dir_t      angle0_i,
    input  wire cordic_pkg::dir_t      angle1_i,
    output cordic_pkg::data_t          x0_o,
    output cordic_pkg::data_t          y0_o,
    output cordic_pkg::data_t          x1_o,
    output cordic_pkg::data_t          y1_o,
    output cordic_pkg::dir_t           dir0_o,
    output cordic_pkg::dir_t           dir1_o,
    output cordic_pkg::seg_valid_t     dir_valid0_o,
    output cordic_pkg::seg_valid_t     dir_valid1_o
);

    logic                       swap_now;
    logic [`CORDIC_LATENCY-1:0] swap_q;
    cordic_pkg::mode_e          mode0;
    cordic_pkg::mode_e          mode1;
    cordic_pkg::data_t          lane0_y_in;
    cordic_pkg::data_t          lane1_x_in;
    cordic_pkg::data_t          lane0_x_out;
    cordic_pkg::data_t          lane0_y_out;
    cordic_pkg::data_t          lane1_x_out;
    cordic_pkg::data_t          lane1_y_out;
    cordic_pkg::dir_t           lane0_dir;
    cordic_pkg::dir_t           lane1_dir;
    cordic_pkg::seg_valid_t     lane0_flags;
    cordic_pkg::seg_valid_t     lane1_flags;
    cordic_pkg::seg_valid_t     swap_seg;
    cordic_pkg::dir_t           swap_bits;

    always_comb begin
        swap_now = 1'b0;
        mode0    = cordic_pkg::ROTATE;
        mode1    = cordic_pkg::ROTATE;
        case (scheme_i)
            pe_pkg::BOTH_VECTOR: begin
                mode0 = cordic_pkg::VECTOR;
                mode1 = cordic_pkg::VECTOR;
            end
            pe_pkg::BOTH_ROTATE: begin
                swap_now = 1'b0;
            end
            pe_pkg::SWAP_VECTOR_ROTATE: begin
                swap_now = 1'b1;
                mode0    = cordic_pkg::VECTOR;
            end
            pe_pkg::SWAP_ROTATE: begin
                swap_now = 1'b1;
            end
        endcase
    end

    // lane 0 takes (x0, x1), lane 1 takes (y0, y1) when swapped
    assign lane0_y_in = swap_now ? x1_i : y0_i;
    assign lane1_x_in = swap_now ? y0_i : x1_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            swap_q <= '0;
        end else begin
            swap_q <= {swap_q[`CORDIC_LATENCY-2:0], swap_now};
        end
    end

    cordic_vr i_lane0 (
        .clk(clk), .rst_n(rst_n), .start_i(lane_valid_i[0]), .mode_i(mode0),
        .x_i(x0_i), .y_i(lane0_y_in), .dir_i(angle0_i),
        .x_o(lane0_x_out), .y_o(lane0_y_out), .dir_o(lane0_dir), .dir_valid_o(lane0_flags)
    );

    cordic_vr i_lane1 (
        .clk(clk), .rst_n(rst_n), .start_i(lane_valid_i[1]), .mode_i(mode1),
        .x_i(lane1_x_in), .y_i(y1_i), .dir_i(angle1_i),
        .x_o(lane1_x_out), .y_o(lane1_y_out), .dir_o(lane1_dir), .dir_valid_o(lane1_flags)
    );

    assign x0_o = lane0_x_out;
    assign y0_o = swap_q[`CORDIC_LATENCY-1] ? lane1_x_out : lane0_y_out;
    assign x1_o = swap_q[`CORDIC_LATENCY-1] ? lane0_y_out : lane1_x_out;
    assign y1_o = lane1_y_out;

    // swap flag as seen by each segment in its own cycle
    assign swap_seg  = {swap_q[1], swap_q[0], swap_now};
    assign swap_bits = cordic_pkg::seg_mask(swap_seg);

    assign dir0_o       = lane0_dir;
    assign dir1_o       = (lane1_dir & ~swap_bits) | (lane0_dir & swap_bits);
    assign dir_valid0_o = lane0_flags;
    assign dir_valid1_o = (lane1_flags & ~swap_seg) | (lane0_flags & swap_seg);

    scheme_known_a: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(scheme_i));

endmodule

`default_nettype wire

//--- src/angle_store.sv
`default_nettype none

module angle_store (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire cordic_pkg::dir_t       dir0_i,
    input  wire cordic_pkg::dir_t       dir1_i,
    input  wire cordic_pkg::seg_valid_t dir_valid0_i,
    input  wire cordic_pkg::seg_valid_t dir_valid1_i,
    output cordic_pkg::dir_t            angle0_o,
    output cordic_pkg::dir_t            angle1_o,
    output cordic_pkg::dir_t            angle0_fwd_o,
    output cordic_pkg::dir_t            angle1_fwd_o
);

    cordic_pkg::dir_t mask0;
    cordic_pkg::dir_t mask1;

    assign mask0 = cordic_pkg::seg_mask(dir_valid0_i);
    assign mask1 = cordic_pkg::seg_mask(dir_valid1_i);

    // fresh segments bypass the register
    assign angle0_fwd_o = (angle0_o & ~mask0) | (dir0_i & mask0);
    assign angle1_fwd_o = (angle1_o & ~mask1) | (dir1_i & mask1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            angle0_o <= '0;
            angle1_o <= '0;
        end else begin
            angle0_o <= angle0_fwd_o;
            angle1_o <= angle1_fwd_o;
        end
    end

    // a vectoring result arrives one segment per cycle
    seg_order0_a: assert property (@(posedge clk) disable iff (!rst_n)
        (dir_valid0_i[2:1] & ~$past(dir_valid0_i[1:0])) == '0);
    seg_order1_a: assert property (@(posedge clk) disable iff (!rst_n)
        (dir_valid1_i[2:1] & ~$past(dir_valid1_i[1:0])) == '0);

endmodule

`default_nettype wire

//--- src/givens_pe_top.sv
`default_nettype none

module givens_pe_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire pe_pkg::lane_valid_t   lane_valid_i,
    input  wire pe_pkg::scheme_e       scheme_i,
    input  wire cordic_pkg::data_t     x0_i,
    input  wire cordic_pkg::data_t     y0_i,
    input  wire cordic_pkg::data_t     x1_i,
    input  wire cordic_pkg::data_t     y1_i,
    output cordic_pkg::data_t          x0_o,
    output cordic_pkg::data_t          y0_o,
    output cordic_pkg::data_t          x1_o,
    output cordic_pkg::data_t          y1_o,
    output cordic_pkg::dir_t           angle0_o,
    output cordic_pkg::dir_t           angle1_o
);

    cordic_pkg::dir_t       dir0;
    cordic_pkg::dir_t       dir1;
    cordic_pkg::seg_valid_t dir_valid0;
    cordic_pkg::seg_valid_t dir_valid1;
    cordic_pkg::dir_t       angle0_fwd;
    cordic_pkg::dir_t       angle1_fwd;

    givens_pe i_pe (
        .clk(clk), .rst_n(rst_n), .lane_valid_i(lane_valid_i), .scheme_i(scheme_i),
        .x0_i(x0_i), .y0_i(y0_i), .x1_i(x1_i), .y1_i(y1_i),
        .angle0_i(angle0_fwd), .angle1_i(angle1_fwd),
        .x0_o(x0_o), .y0_o(y0_o), .x1_o(x1_o), .y1_o(y1_o),
        .dir0_o(dir0), .dir1_o(dir1), .dir_valid0_o(dir_valid0), .dir_valid1_o(dir_valid1)
    );

    angle_store i_angles (
        .clk(clk), .rst_n(rst_n),
        .dir0_i(dir0), .dir1_i(dir1), .dir_valid0_i(dir_valid0), .dir_valid1_i(dir_valid1),
        .angle0_o(angle0_o), .angle1_o(angle1_o),
        .angle0_fwd_o(angle0_fwd), .angle1_fwd_o(angle1_fwd)
    );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        forever #5 clk_o = ~clk_o;     // period 10
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/tb_givens_pe.sv
`default_nettype none

`include "cordic_params.svh"

module tb_givens_pe;

    localparam int  RESET_CYCLES = 16;
    localparam int  TESTS        = 5;
    localparam int  LIMIT        = RESET_CYCLES + 40 * TESTS;
    localparam int  L            = `CORDIC_LATENCY;
    localparam real TOL          = 24.0;   // LSB, truncation of 14 micro-rotations plus gain

    logic                 clk;
    logic                 rst_n;
    pe_pkg::lane_valid_t  lane_valid_i;
    pe_pkg::scheme_e      scheme_i;
    cordic_pkg::data_t    x0_i, y0_i, x1_i, y1_i;
    cordic_pkg::data_t    x0_o, y0_o, x1_o, y1_o;
    cordic_pkg::dir_t     angle0_o, angle1_o;
    cordic_pkg::dir_t     held0, held1;

    // expectation launched with the operands, then delayed to the output cycle
    logic [3:0]        l_en;
    real               l_exp [4];
    logic              l_nen, l_nsel;
    real               l_norm;
    logic [3:0]        d_en [L];
    real               d_exp [L][4];
    logic              d_nen [L];
    logic              d_nsel [L];
    real               d_norm [L];
    cordic_pkg::data_t outs [4];
    logic              ok [4];
    longint            exp_i [4];
    logic              norm_ok;
    real               norm_got;
    logic              zero_chk, eq_chk, hold_chk;
    logic [31:0]       seed = 32'hec54;
    int                cycles = 0;
    string             names [4] = '{"x0_o", "y0_o", "x1_o", "y1_o"};

    tb_clk_gen #(.RESET_CYCLES(RESET_CYCLES)) i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    givens_pe_top i_dut (
        .clk(clk), .rst_n(rst_n), .lane_valid_i(lane_valid_i), .scheme_i(scheme_i),
        .x0_i(x0_i), .y0_i(y0_i), .x1_i(x1_i), .y1_i(y1_i),
        .x0_o(x0_o), .y0_o(y0_o), .x1_o(x1_o), .y1_o(y1_o),
        .angle0_o(angle0_o), .angle1_o(angle1_o)
    );

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic real mag(int a, int b);
        return $sqrt(real'(a) * real'(a) + real'(b) * real'(b));
    endfunction

    function automatic real real_abs(real v);
        return (v < 0.0) ? -v : v;
    endfunction

    task automatic run_fail(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_fail(input string name, input longint got, input longint exp);
        run_fail($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // quarter full scale at most
    task automatic draw(input bit positive, output int v);
        seed = lcg_next(seed);
        v = int'(seed[30:16]);
        if (!positive && seed[31]) v = -v;
    endtask

    task automatic launch(input pe_pkg::scheme_e s, input int a, input int b, input int c,
                          input int d, input logic [3:0] en, input real e0, input real e1,
                          input real e2, input real e3, input logic nen, input logic nsel,
                          input real nv);
        @(posedge clk);
        lane_valid_i <= 2'b11;
        scheme_i     <= s;
        x0_i         <= cordic_pkg::data_t'(a);
        y0_i         <= cordic_pkg::data_t'(b);
        x1_i         <= cordic_pkg::data_t'(c);
        y1_i         <= cordic_pkg::data_t'(d);
        l_en         <= en;
        l_exp[0]     <= e0;
        l_exp[1]     <= e1;
        l_exp[2]     <= e2;
        l_exp[3]     <= e3;
        l_nen        <= nen;
        l_nsel       <= nsel;
        l_norm       <= nv;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            lane_valid_i <= '0;
            l_en         <= '0;
            l_nen        <= 1'b0;
        end
    endtask

    always @(posedge clk) begin
        d_en[0]   <= l_en;
        d_exp[0]  <= l_exp;
        d_nen[0]  <= l_nen;
        d_nsel[0] <= l_nsel;
        d_norm[0] <= l_norm;
        for (int k = 1; k < L; k++) begin
            d_en[k]   <= d_en[k-1];
            d_exp[k]  <= d_exp[k-1];
            d_nen[k]  <= d_nen[k-1];
            d_nsel[k] <= d_nsel[k-1];
            d_norm[k] <= d_norm[k-1];
        end
    end

    assign outs[0] = x0_o;
    assign outs[1] = y0_o;
    assign outs[2] = x1_o;
    assign outs[3] = y1_o;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            ok[i]    = !d_en[L-1][i] || real_abs(real'(outs[i]) - d_exp[L-1][i]) <= TOL;
            exp_i[i] = longint'($rtoi(d_exp[L-1][i]));
        end
        if (d_nsel[L-1]) begin
            norm_got = $sqrt(real'(y0_o) * real'(y0_o) + real'(y1_o) * real'(y1_o));
        end else begin
            norm_got = $sqrt(real'(x0_o) * real'(x0_o) + real'(y0_o) * real'(y0_o));
        end
        norm_ok = !d_nen[L-1] || real_abs(norm_got - d_norm[L-1]) <= TOL;
    end

    for (genvar i = 0; i < 4; i++) begin : g_out_chk
        out_a: assert property (@(posedge clk) disable iff (!rst_n) ok[i])
            else value_fail(names[i], longint'($sampled(outs[i])), $sampled(exp_i[i]));
    end

    norm_a: assert property (@(posedge clk) disable iff (!rst_n) norm_ok)
        else value_fail("norm of output pair", longint'($rtoi($sampled(norm_got))),
                        longint'($rtoi($sampled(d_norm[L-1]))));
    zero_data_a: assert property (@(posedge clk) disable iff (!rst_n)
        zero_chk |-> (x0_o | y0_o | x1_o | y1_o) == '0)
        else value_fail("x0_o|y0_o|x1_o|y1_o",
                        longint'($sampled(x0_o | y0_o | x1_o | y1_o)), 0);
    zero_angle_a: assert property (@(posedge clk) disable iff (!rst_n)
        zero_chk |-> (angle0_o | angle1_o) == '0)
        else value_fail("angle0_o|angle1_o", longint'($sampled(angle0_o | angle1_o)), 0);
    angle_eq_a: assert property (@(posedge clk) disable iff (!rst_n)
        eq_chk |-> angle1_o == angle0_o)
        else value_fail("angle1_o", longint'($sampled(angle1_o)), longint'($sampled(angle0_o)));
    hold0_a: assert property (@(posedge clk) disable iff (!rst_n)
        hold_chk |-> angle0_o == held0)
        else value_fail("angle0_o", longint'($sampled(angle0_o)), longint'($sampled(held0)));
    hold1_a: assert property (@(posedge clk) disable iff (!rst_n)
        hold_chk |-> angle1_o == held1)
        else value_fail("angle1_o", longint'($sampled(angle1_o)), longint'($sampled(held1)));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            run_fail($sformatf("timeout, run did not end within %0d cycles", LIMIT));
        end
    end

    initial begin
        int a, b, c, d, p, q;
        lane_valid_i <= '0;
        scheme_i     <= pe_pkg::BOTH_VECTOR;
        x0_i         <= '0;
        y0_i         <= '0;
        x1_i         <= '0;
        y1_i         <= '0;
        l_en         <= '0;
        l_nen        <= 1'b0;
        l_nsel       <= 1'b0;
        zero_chk     <= 1'b0;
        eq_chk       <= 1'b0;
        hold_chk     <= 1'b0;
        wait (rst_n);
        // reset state
        @(posedge clk);
        zero_chk <= 1'b1;
        idle(4);
        zero_chk <= 1'b0;
        // vectoring, x kept positive for convergence
        for (int i = 0; i < 6; i++) begin
            draw(1'b1, a);
            draw(1'b0, b);
            draw(1'b1, c);
            draw(1'b0, d);
            launch(pe_pkg::BOTH_VECTOR, a, b, c, d, 4'b1111,
                   mag(a, b), 0.0, mag(c, d), 0.0, 1'b0, 1'b0, 0.0);
        end
        idle(8);
        // rotation by the stored angles of the last pairs
        launch(pe_pkg::BOTH_ROTATE, a, b, c, d, 4'b1111,
               mag(a, b), 0.0, mag(c, d), 0.0, 1'b0, 1'b0, 0.0);
        draw(1'b0, p);
        draw(1'b0, q);
        launch(pe_pkg::BOTH_ROTATE, p, q, q, p, 4'b0000,
               0.0, 0.0, 0.0, 0.0, 1'b1, 1'b0, mag(p, q));
        idle(8);
        // swapped lanes, lane 1 follows lane 0's fresh bits
        draw(1'b1, a);
        draw(1'b0, b);
        draw(1'b0, c);
        draw(1'b0, d);
        launch(pe_pkg::SWAP_VECTOR_ROTATE, a, c, b, d, 4'b0101,
               mag(a, b), 0.0, 0.0, 0.0, 1'b1, 1'b1, mag(c, d));
        idle(8);
        eq_chk <= 1'b1;
        idle(2);
        eq_chk <= 1'b0;
        // idle lanes under random schemes
        held0    <= angle0_o;
        held1    <= angle1_o;
        hold_chk <= 1'b1;
        repeat (32) begin
            @(posedge clk);
            seed = lcg_next(seed);
            lane_valid_i <= '0;
            scheme_i     <= pe_pkg::scheme_e'(seed[1:0]);
            x0_i         <= cordic_pkg::data_t'(seed[19:2]);
            y1_i         <= cordic_pkg::data_t'(seed[31:14]);
        end
        @(posedge clk);
        hold_chk <= 1'b0;
        idle(2);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- givens_pe_top.f
+incdir+src
src/cordic_pkg.sv
src/pe_pkg.sv
src/cordic_segment.sv
src/cordic_vr.sv
src/givens_pe.sv
src/angle_store.sv
src/givens_pe_top.sv
tests/tb_clk_gen.sv
tests/tb_givens_pe.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := tb_givens_pe
FLIST     := givens_pe_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
